// ==== verilog/msx_glue_consts.svh ====
`ifndef MSX_GLUE_CONSTS_SVH
`define MSX_GLUE_CONSTS_SVH

// APB register offsets
`define MSX_REG_CFG    0
`define MSX_REG_HDMI   4
`define MSX_REG_CMD    8
`define MSX_REG_STATUS 12

// Download index of cassette images
`define MSX_CAS_INDEX 5

// 1080p output and the matching crop
`define MSX_HDMI_W_1080 1920
`define MSX_HDMI_H_1080 1080
`define MSX_CROP_216    216

// Original 4:3 aspect
`define MSX_AR_DEF_X 4
`define MSX_AR_DEF_Y 3

// Disk LED hold time in clock cycles
`define MSX_SD_ACT_HOLD 1000000

`endif

// ==== verilog/msx_glue_pkg.sv ====
`default_nettype none

package msx_glue_pkg;

   // ==================================================
   // APB
   // ==================================================
   typedef struct packed {
      logic [3:0]  paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // ==================================================
   // Configuration and status
   // ==================================================
   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } aspect_t;

   typedef struct packed {
      aspect_t     aspect;
      logic [2:0]  scale;
      logic        tape_from_file;
      logic [11:0] hdmi_width;
      logic [11:0] hdmi_height;
   } glue_cfg_t;

   // Outputs of one SPI master
   typedef struct packed {
      logic sck;
      logic mosi;
      logic ss;
      logic enable;
   } spi_lines_t;

   // Bit 2 vsd_sel, bit 1 sd_act, bit 0 cas_load
   typedef struct packed {
      logic vsd_sel;
      logic sd_act;
      logic cas_load;
   } glue_status_t;

   typedef struct packed {
      logic [1:0]  vga_sl;
      logic        hq2x;
      logic        scandoubler;
      logic [11:0] arx;
      logic [11:0] ary;
      logic [11:0] crop_size;
   } video_ctl_t;

endpackage

`default_nettype wire

// ==== verilog/msx_glue_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module msx_glue_regs
   import msx_glue_pkg::*;
(
   input  logic         clock_bus,
   input  logic         rst_n,
   input  apb_req_t     apb_req,
   output apb_rsp_t     apb_rsp,
   output glue_cfg_t    cfg,
   output logic         tape_rewind,
   input  glue_status_t status
);

   logic access;
   logic wr_en;
   logic unmapped;

   assign access = apb_req.psel & apb_req.penable;
   assign wr_en  = access & apb_req.pwrite;

   // ==================================================
   // Register writes on the access-phase edge
   // ==================================================
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         cfg         <= '0;
         tape_rewind <= 1'b0;
      end else begin
         // Rewind lasts one cycle only
         tape_rewind <= 1'b0;
         if (wr_en) begin
            case (apb_req.paddr)
               `MSX_REG_CFG: begin
                  cfg.aspect         <= aspect_t'(apb_req.pwdata[1:0]);
                  cfg.scale          <= apb_req.pwdata[4:2];
                  cfg.tape_from_file <= apb_req.pwdata[5];
               end
               `MSX_REG_HDMI: begin
                  cfg.hdmi_width  <= apb_req.pwdata[11:0];
                  cfg.hdmi_height <= apb_req.pwdata[23:12];
               end
               `MSX_REG_CMD: begin
                  tape_rewind <= apb_req.pwdata[0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // ==================================================
   // Read mux, no wait states
   // ==================================================
   always_comb begin
      unmapped       = 1'b0;
      apb_rsp.prdata = '0;
      case (apb_req.paddr)
         `MSX_REG_CFG:
            apb_rsp.prdata = {26'd0, cfg.tape_from_file, cfg.scale, cfg.aspect};
         `MSX_REG_HDMI:
            apb_rsp.prdata = {8'd0, cfg.hdmi_height, cfg.hdmi_width};
         `MSX_REG_CMD:
            apb_rsp.prdata = '0;
         `MSX_REG_STATUS:
            apb_rsp.prdata = {29'd0, status};
         default:
            unmapped = 1'b1;
      endcase
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = access & unmapped;
   end

endmodule

`default_nettype wire

// ==== verilog/sd_route.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module sd_route
   import msx_glue_pkg::*;
#(
   parameter int act_hold = `MSX_SD_ACT_HOLD
) (
   input  logic        clock_bus,
   input  logic        rst_n,
   input  spi_lines_t  ese_spi,
   input  spi_lines_t  megasd_spi,
   input  logic        vsd_mounted,
   input  logic [63:0] vsd_size,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        sd_cs,
   output logic        vsd_sck,
   output logic        vsd_mosi,
   output logic        vsd_cs,
   output logic        core_miso,
   output logic        vsd_sel,
   output logic        sd_act,
   output logic [1:0]  led_disk
);

   localparam int cnt_w = $clog2(act_hold + 1);

   logic             bus_sck;
   logic             bus_mosi;
   logic             bus_ss;
   logic             old_mosi;
   logic             old_miso;
   logic [cnt_w-1:0] hold_cnt;

   // ESE master wins when enabled, MegaSD has no chip select
   assign bus_sck  = ese_spi.enable ? ese_spi.sck  : megasd_spi.sck;
   assign bus_mosi = ese_spi.enable ? ese_spi.mosi : megasd_spi.mosi;
   assign bus_ss   = ese_spi.enable ? ese_spi.ss   : 1'b0;

   // Physical card parked while the virtual card is in use
   assign sd_cs     = vsd_sel | bus_ss;
   assign sd_sck    = bus_sck & ~vsd_sel;
   assign sd_mosi   = bus_mosi & ~vsd_sel;
   assign vsd_cs    = ~vsd_sel | bus_ss;
   assign vsd_sck   = bus_sck;
   assign vsd_mosi  = bus_mosi;
   assign core_miso = vsd_sel ? vsd_miso : sd_miso;

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (vsd_mounted) begin
         vsd_sel <= |vsd_size;
      end
   end

   // ==================================================
   // Activity detector for the disk LED
   // ==================================================
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         hold_cnt <= cnt_w'(act_hold);
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= bus_mosi;
         old_miso <= core_miso;
         if ((old_mosi ^ bus_mosi) | (old_miso ^ core_miso)) begin
            hold_cnt <= '0;
            sd_act   <= 1'b1;
         end else if (hold_cnt < cnt_w'(act_hold)) begin
            hold_cnt <= hold_cnt + 1'b1;
            sd_act   <= 1'b1;
         end else begin
            sd_act <= 1'b0;
         end
      end
   end

   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

`default_nettype wire

// ==== verilog/tape_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module tape_ctrl
   import msx_glue_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst_n,
   input  glue_cfg_t   cfg,
   input  logic        tape_rewind,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        motor,
   input  logic        cas_dout,
   input  logic        tape_adc,
   input  logic        tape_adc_act,
   output logic        cas_load,
   output logic        play,
   output logic        rewind,
   output logic        tape_in
);

   logic cas_active;
   logic cas_active_q;

   // Cassette image being downloaded
   assign cas_active = ioctl_download & (ioctl_index[5:0] == 6'(`MSX_CAS_INDEX));

   // ==================================================
   // CAS load flag, set when the download ends
   // ==================================================
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         cas_active_q <= 1'b0;
         cas_load     <= 1'b0;
      end else begin
         cas_active_q <= cas_active;
         if (cas_active_q & ~cas_active) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Player runs with the motor relay open
   assign play   = cas_load & ~motor;
   assign rewind = tape_rewind | cas_active | ~rst_n;

   // File player or ADC input
   assign tape_in = cfg.tape_from_file ? cas_dout : (tape_adc & tape_adc_act);

endmodule

`default_nettype wire

// ==== verilog/video_opts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module video_opts
   import msx_glue_pkg::*;
(
   input  logic       clock_bus,
   input  logic       rst_n,
   input  glue_cfg_t  cfg,
   input  logic       forced_scandoubler,
   output video_ctl_t video
);

   logic [1:0]  sl;
   logic        is_original;
   logic [11:0] crop_q;

   // Scanline level is scale minus one
   assign sl          = (cfg.scale != 3'd0) ? 2'(cfg.scale - 3'd1) : 2'd0;
   assign is_original = (cfg.aspect == AR_ORIGINAL);

   // ==================================================
   // 216-line crop for 1080p output
   // ==================================================
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         crop_q <= '0;
      end else if ((cfg.hdmi_width == 12'(`MSX_HDMI_W_1080)) &&
                   (cfg.hdmi_height == 12'(`MSX_HDMI_H_1080)) &&
                   !forced_scandoubler && (cfg.scale != 3'd0)) begin
         crop_q <= 12'(`MSX_CROP_216);
      end else begin
         crop_q <= '0;
      end
   end

   always_comb begin
      video.vga_sl      = sl;
      video.hq2x        = (cfg.scale == 3'd1);
      video.scandoubler = (cfg.scale != 3'd0) | forced_scandoubler;
      // Custom aspects pass their index down
      video.arx         = is_original ? 12'(`MSX_AR_DEF_X)
                                      : {10'd0, 2'(cfg.aspect - 2'd1)};
      video.ary         = is_original ? 12'(`MSX_AR_DEF_Y) : 12'd0;
      video.crop_size   = crop_q;
   end

endmodule

`default_nettype wire

// ==== verilog/msx_glue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module msx_glue_top
   import msx_glue_pkg::*;
#(
   parameter int act_hold = `MSX_SD_ACT_HOLD
) (
   input  logic        clock_bus,
   input  logic        rst_n,
   input  apb_req_t    apb_req,
   output apb_rsp_t    apb_rsp,
   // SD
   input  spi_lines_t  ese_spi,
   input  spi_lines_t  megasd_spi,
   input  logic        vsd_mounted,
   input  logic [63:0] vsd_size,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        sd_cs,
   output logic        vsd_sck,
   output logic        vsd_mosi,
   output logic        vsd_cs,
   output logic        core_miso,
   output logic [1:0]  led_disk,
   // Tape
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        motor,
   input  logic        cas_dout,
   input  logic        tape_adc,
   input  logic        tape_adc_act,
   output logic        play,
   output logic        rewind,
   output logic        tape_in,
   // Video
   input  logic        forced_scandoubler,
   output video_ctl_t  video
);

   glue_cfg_t    cfg;
   glue_status_t status;
   logic         tape_rewind;
   logic         vsd_sel;
   logic         sd_act;
   logic         cas_load;

   // Live status for the STATUS register
   assign status.vsd_sel  = vsd_sel;
   assign status.sd_act   = sd_act;
   assign status.cas_load = cas_load;

   msx_glue_regs u_regs (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .cfg         (cfg),
      .tape_rewind (tape_rewind),
      .status      (status)
   );

   sd_route #(
      .act_hold (act_hold)
   ) u_sd_route (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .ese_spi     (ese_spi),
      .megasd_spi  (megasd_spi),
      .vsd_mounted (vsd_mounted),
      .vsd_size    (vsd_size),
      .sd_miso     (sd_miso),
      .vsd_miso    (vsd_miso),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .sd_cs       (sd_cs),
      .vsd_sck     (vsd_sck),
      .vsd_mosi    (vsd_mosi),
      .vsd_cs      (vsd_cs),
      .core_miso   (core_miso),
      .vsd_sel     (vsd_sel),
      .sd_act      (sd_act),
      .led_disk    (led_disk)
   );

   tape_ctrl u_tape_ctrl (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .cfg            (cfg),
      .tape_rewind    (tape_rewind),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .motor          (motor),
      .cas_dout       (cas_dout),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .cas_load       (cas_load),
      .play           (play),
      .rewind         (rewind),
      .tape_in        (tape_in)
   );

   video_opts u_video_opts (
      .clock_bus          (clock_bus),
      .rst_n              (rst_n),
      .cfg                (cfg),
      .forced_scandoubler (forced_scandoubler),
      .video              (video)
   );

endmodule

`default_nettype wire

// ==== verif/msx_glue_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_glue_asserts
   import msx_glue_pkg::*;
(
   input logic     clock_bus,
   input logic     rst_n,
   input apb_rsp_t apb_rsp,
   input logic     sd_cs,
   input logic     vsd_sel,
   input logic     play,
   input logic     cas_load,
   input logic     sd_act
);

   // Number of assertion failures so far
   int assert_errors = 0;

   // APB slave has no wait states
   pready_high: assert property (@(posedge clock_bus) disable iff (!rst_n) apb_rsp.pready)
      else begin
         $error("pready went low");
         assert_errors++;
      end

   // Physical card parked under the virtual card
   card_parked: assert property (@(posedge clock_bus) disable iff (!rst_n) vsd_sel |-> sd_cs)
      else begin
         $error("sd_cs low while the virtual card is selected");
         assert_errors++;
      end

   play_needs_load: assert property (@(posedge clock_bus) disable iff (!rst_n)
                                     play |-> cas_load)
      else begin
         $error("play high without cas_load");
         assert_errors++;
      end

   act_quiet_after_reset: assert property (@(posedge clock_bus) $rose(rst_n) |=> !sd_act)
      else begin
         $error("sd_act high in the first cycle out of reset");
         assert_errors++;
      end

endmodule

bind msx_glue_top msx_glue_asserts u_asserts (
   .clock_bus (clock_bus),
   .rst_n     (rst_n),
   .apb_rsp   (apb_rsp),
   .sd_cs     (sd_cs),
   .vsd_sel   (vsd_sel),
   .play      (play),
   .cas_load  (cas_load),
   .sd_act    (sd_act)
);

`default_nettype wire

// ==== verif/msx_glue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_consts.svh"

module msx_glue_tb
   import msx_glue_pkg::*;
();

   logic         clock_bus;
   logic         rst_n;
   apb_req_t     apb_req;
   apb_rsp_t     apb_rsp;
   spi_lines_t   ese_spi;
   spi_lines_t   megasd_spi;
   logic         vsd_mounted;
   logic [63:0]  vsd_size;
   logic         sd_miso;
   logic         vsd_miso;
   logic         sd_sck;
   logic         sd_mosi;
   logic         sd_cs;
   logic         vsd_sck;
   logic         vsd_mosi;
   logic         vsd_cs;
   logic         core_miso;
   logic [1:0]   led_disk;
   logic         ioctl_download;
   logic [15:0]  ioctl_index;
   logic         motor;
   logic         cas_dout;
   logic         tape_adc;
   logic         tape_adc_act;
   logic         play;
   logic         rewind;
   logic         tape_in;
   logic         forced_scandoubler;
   video_ctl_t   video;

   int           value_errors;
   int           other_errors;
   logic [31:0]  rng_state;
   // HDMI size as last written over APB
   logic [11:0]  hdmi_w;
   logic [11:0]  hdmi_h;

   msx_glue_top #(.act_hold(64)) dut (.*);

   initial begin
      clock_bus = 1'b0;
      forever #20 clock_bus = ~clock_bus;
   end

   // Whole test sequence takes a few hundred cycles
   initial begin
      repeat (4000) @(posedge clock_bus);
      $display("Watchdog expired after 4000 cycles, the tests did not finish");
      $display("Test failed");
      $finish;
   end

   // ==================================================
   // Helpers
   // ==================================================
   function logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Leaves the time 2 ns after a rising edge
   task automatic tick(input int n);
      repeat (n) @(posedge clock_bus);
      #2;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      apb_req.pwrite  = 1'b1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      tick(1);
      apb_req.penable = 1'b1;
      tick(1);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic err);
      apb_req.paddr   = addr;
      apb_req.pwrite  = 1'b0;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      tick(1);
      apb_req.penable = 1'b1;
      #10;
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      tick(1);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_video(input string name, input video_ctl_t expected,
                              input video_ctl_t actual);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_status(input string name, input glue_status_t expected,
                               input glue_status_t actual);
      if (actual !== expected) begin
         value_errors++;
         $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   function automatic video_ctl_t expected_video(input logic [1:0] aspect,
                                                 input logic [2:0] scale,
                                                 input logic forced);
      video_ctl_t v;
      v.vga_sl      = (scale == 3'd0) ? 2'd0 : scale[1:0] - 2'd1;
      v.hq2x        = (scale == 3'd1);
      v.scandoubler = (scale != 3'd0) || forced;
      v.arx         = (aspect == 2'd0) ? 12'd4 : 12'(aspect) - 12'd1;
      v.ary         = (aspect == 2'd0) ? 12'd3 : 12'd0;
      v.crop_size   = 12'd0;
      if (hdmi_w == 12'd1920 && hdmi_h == 12'd1080 && !forced && scale != 3'd0)
         v.crop_size = 12'd216;
      return v;
   endfunction

   // One random SPI pattern, card lines checked against the selected target
   task automatic route_step(input logic sel);
      logic [31:0] r;
      spi_lines_t  src;
      logic        ss;
      r          = next_random();
      ese_spi    = r[3:0];
      megasd_spi = r[7:4];
      sd_miso    = r[8];
      vsd_miso   = r[9];
      #1;
      src = ese_spi.enable ? ese_spi : megasd_spi;
      ss  = ese_spi.enable & ese_spi.ss;
      check_bit("sd_sck", sel ? 1'b0 : src.sck, sd_sck);
      check_bit("sd_mosi", sel ? 1'b0 : src.mosi, sd_mosi);
      check_bit("sd_cs", sel ? 1'b1 : ss, sd_cs);
      check_bit("vsd_cs", sel ? ss : 1'b1, vsd_cs);
      check_bit("core_miso", sel ? vsd_miso : sd_miso, core_miso);
      if (sel) begin
         check_bit("vsd_sck", src.sck, vsd_sck);
         check_bit("vsd_mosi", src.mosi, vsd_mosi);
      end
      tick(1);
   endtask

   task automatic mount_card(input logic [63:0] size);
      vsd_size    = size;
      vsd_mounted = 1'b1;
      tick(1);
      vsd_mounted = 1'b0;
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic test_registers();
      logic [31:0] data;
      logic [31:0] rd;
      logic        err;
      check_bit("play after reset", 1'b0, play);
      check_bit("rewind after reset", 1'b0, rewind);
      apb_read(`MSX_REG_STATUS, rd, err);
      check_status("STATUS after reset", '0, glue_status_t'(rd[2:0]));
      check_bit("pslverr", 1'b0, err);
      data = next_random();
      apb_write(`MSX_REG_CFG, data);
      apb_read(`MSX_REG_CFG, rd, err);
      check_word("CFG", data & 32'h0000_003f, rd);
      data = next_random();
      apb_write(`MSX_REG_HDMI, data);
      hdmi_w = data[11:0];
      hdmi_h = data[23:12];
      apb_read(`MSX_REG_HDMI, rd, err);
      check_word("HDMI", data & 32'h00ff_ffff, rd);
      apb_write(`MSX_REG_CMD, 32'h1);
      apb_read(`MSX_REG_CMD, rd, err);
      check_word("CMD", 32'h0, rd);
      apb_read(4'd2, rd, err);
      check_bit("pslverr", 1'b1, err);
      check_word("prdata unmapped", 32'h0, rd);
   endtask

   task automatic test_video();
      for (int a = 0; a < 4; a++) begin
         for (int s = 0; s < 5; s++) begin
            apb_write(`MSX_REG_CFG, {26'd0, 1'b0, 3'(s), 2'(a)});
            tick(2);
            check_video("video", expected_video(2'(a), 3'(s), 1'b0), video);
         end
      end
      apb_write(`MSX_REG_HDMI, {8'd0, 12'd1080, 12'd1920});
      hdmi_w = 12'd1920;
      hdmi_h = 12'd1080;
      apb_write(`MSX_REG_CFG, {26'd0, 1'b0, 3'd2, 2'd0});
      tick(2);
      check_video("video 1080p", expected_video(2'd0, 3'd2, 1'b0), video);
      check_word("crop_size", 32'd216, 32'(video.crop_size));
      forced_scandoubler = 1'b1;
      tick(2);
      check_video("video forced", expected_video(2'd0, 3'd2, 1'b1), video);
      forced_scandoubler = 1'b0;
   endtask

   task automatic test_sd_routing();
      logic [31:0] rd;
      logic        err;
      repeat (8) route_step(1'b0);
      mount_card({next_random(), next_random()} | 64'd1);
      repeat (8) route_step(1'b1);
      apb_read(`MSX_REG_STATUS, rd, err);
      check_bit("STATUS.vsd_sel", 1'b1, rd[2]);
      mount_card(64'd0);
      repeat (8) route_step(1'b0);
   endtask

   task automatic test_activity();
      logic [31:0] rd;
      logic        err;
      int          n;
      ese_spi    = '{sck: 1'b0, mosi: 1'b0, ss: 1'b1, enable: 1'b1};
      megasd_spi = '0;
      sd_miso    = 1'b0;
      vsd_miso   = 1'b0;
      tick(70);
      check_bit("led_disk[0] idle", 1'b0, led_disk[0]);
      ese_spi.mosi = 1'b1;
      n = 0;
      while (!led_disk[0] && n < 2) begin
         tick(1);
         n++;
      end
      if (!led_disk[0]) begin
         other_errors++;
         $display("Disk LED did not light within 2 cycles of a mosi change");
      end
      check_bit("led_disk[1]", 1'b1, led_disk[1]);
      apb_read(`MSX_REG_STATUS, rd, err);
      check_bit("STATUS.sd_act", 1'b1, rd[1]);
      tick(70);
      check_bit("led_disk[0] after hold", 1'b0, led_disk[0]);
      apb_read(`MSX_REG_STATUS, rd, err);
      check_status("STATUS quiet", '0, glue_status_t'(rd[2:0]));
   endtask

   task automatic test_cassette();
      logic [31:0] rd;
      logic        err;
      int          n;
      motor          = 1'b0;
      // Download of some other file leaves the flag clear
      ioctl_index    = 16'h0003;
      ioctl_download = 1'b1;
      repeat (3) begin
         tick(1);
         check_bit("rewind other download", 1'b0, rewind);
      end
      ioctl_download = 1'b0;
      tick(2);
      apb_read(`MSX_REG_STATUS, rd, err);
      check_bit("STATUS.cas_load other download", 1'b0, rd[0]);
      check_bit("play before load", 1'b0, play);
      ioctl_index    = 16'(`MSX_CAS_INDEX);
      ioctl_download = 1'b1;
      repeat (5) begin
         tick(1);
         check_bit("rewind in download", 1'b1, rewind);
      end
      ioctl_download = 1'b0;
      n = 0;
      while (!play && n < 2) begin
         tick(1);
         n++;
      end
      if (!play) begin
         other_errors++;
         $display("Play did not start within 2 cycles after the cassette download");
      end
      apb_read(`MSX_REG_STATUS, rd, err);
      check_bit("STATUS.cas_load", 1'b1, rd[0]);
      motor = 1'b1;
      tick(1);
      check_bit("play motor on", 1'b0, play);
      motor = 1'b0;
      tick(1);
      check_bit("play motor off", 1'b1, play);
      apb_write(`MSX_REG_CMD, 32'h1);
      n = 0;
      repeat (4) begin
         if (rewind)
            n++;
         tick(1);
      end
      check_word("rewind pulse cycles", 32'd1, 32'(n));
      apb_write(`MSX_REG_CFG, 32'h20);
      for (int i = 0; i < 4; i++) begin
         cas_dout = i[0];
         tape_adc = ~i[0];
         tick(1);
         check_bit("tape_in file", cas_dout, tape_in);
      end
      apb_write(`MSX_REG_CFG, 32'h0);
      for (int i = 0; i < 4; i++) begin
         tape_adc     = i[0];
         tape_adc_act = i[1];
         cas_dout     = ~i[0];
         tick(1);
         check_bit("tape_in adc", i[0] & i[1], tape_in);
      end
   endtask

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      apb_req            = '0;
      ese_spi            = '0;
      megasd_spi         = '0;
      vsd_mounted        = 1'b0;
      vsd_size           = '0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b0;
      ioctl_download     = 1'b0;
      ioctl_index        = '0;
      motor              = 1'b0;
      cas_dout           = 1'b0;
      tape_adc           = 1'b0;
      tape_adc_act       = 1'b0;
      forced_scandoubler = 1'b0;
      rst_n              = 1'b0;
      value_errors       = 0;
      other_errors       = 0;
      rng_state          = 32'd50;
      hdmi_w             = '0;
      hdmi_h             = '0;
      tick(4);
      rst_n = 1'b1;
      tick(1);
      test_registers();
      test_video();
      test_sd_routing();
      test_activity();
      test_cassette();
      $display("Summary: %0d value mismatches, %0d other errors, %0d assertion failures",
               value_errors, other_errors, dut.u_asserts.assert_errors);
      if (value_errors + other_errors + dut.u_asserts.assert_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/msx_glue_pkg.sv
verilog/msx_glue_regs.sv
verilog/sd_route.sv
verilog/tape_ctrl.sv
verilog/video_opts.sv
verilog/msx_glue_top.sv
verif/msx_glue_asserts.sv
verif/msx_glue_tb.sv

// ==== Bender.yml ====
package:
  name: msx_glue

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/msx_glue_pkg.sv
      - verilog/msx_glue_regs.sv
      - verilog/sd_route.sv
      - verilog/tape_ctrl.sv
      - verilog/video_opts.sv
      - verilog/msx_glue_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/msx_glue_asserts.sv
      - verif/msx_glue_tb.sv
